// File: filelist.f
+incdir+logic
logic/regex_isa_pkg.sv
logic/engine_types_pkg.sv
logic/thread_fifo.sv
logic/thread_arbiter.sv
logic/fetch_arbiter.sv
logic/regex_cpu.sv
logic/thread_counter.sv
logic/vectorial_engine.sv
verification/tb_vectorial_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_vectorial_engine -o tb_vectorial_engine

sim_out=$(./obj_dir/tb_vectorial_engine 2>&1) || true
echo "$sim_out"

if grep -q "TEST RESULT: PASS" <<< "$sim_out"; then
  exit 0
fi
exit 1

// File: verification/tb_vectorial_engine.sv
`timescale 1ns/1ps
`include "regex_consts.svh"

module tb_vectorial_engine;

  localparam int TIMEOUT_CYCLES = 20000;  // roughly 4x the longest run
  localparam logic [31:0] SEED = 32'hdb45cd13;

  // opcode field values, top two bits of an instruction
  localparam logic [1:0] OP_MATCH  = 2'b00;
  localparam logic [1:0] OP_SPLIT  = 2'b01;
  localparam logic [1:0] OP_JMP    = 2'b10;
  localparam logic [1:0] OP_ACCEPT = 2'b11;

  logic                            clk;
  logic                            rst;
  logic [`LANES*`CHAR_WIDTH-1:0]   cur_window;
  engine_types_pkg::lane_mask_t    cur_window_enable;
  logic                            input_pc_valid;
  engine_types_pkg::thread_t       input_pc_and_cc_id;
  logic                            input_pc_ready;
  logic                            output_pc_valid;
  engine_types_pkg::thread_t       output_pc_and_cc_id;
  logic                            output_pc_ready;
  logic                            memory_valid;
  engine_types_pkg::pc_t           memory_addr;
  logic                            memory_ready;
  regex_isa_pkg::instr_t           memory_data;
  logic                            accepts;
  logic                            running;
  engine_types_pkg::thread_count_t thread_count;

  regex_isa_pkg::instr_t prog [128];
  integer mem_seed = SEED;
  integer stim_seed = SEED;

  // expected results of the current case
  int exp_counts [128];
  int exp_accepts;
  int exp_total;
  int run_total;

  // running totals, written by the monitor only
  int got_counts [128];
  int got_accepts;
  int got_total;

  // snapshot taken when a case starts
  int base_counts [128];
  int base_accepts;
  int base_total;

  vectorial_engine u_vectorial_engine (
    .clk                (clk),
    .rst                (rst),
    .cur_window         (cur_window),
    .cur_window_enable  (cur_window_enable),
    .input_pc_valid     (input_pc_valid),
    .input_pc_and_cc_id (input_pc_and_cc_id),
    .input_pc_ready     (input_pc_ready),
    .output_pc_valid    (output_pc_valid),
    .output_pc_and_cc_id(output_pc_and_cc_id),
    .output_pc_ready    (output_pc_ready),
    .memory_valid       (memory_valid),
    .memory_addr        (memory_addr),
    .memory_ready       (memory_ready),
    .memory_data        (memory_data),
    .accepts            (accepts),
    .running            (running),
    .thread_count       (thread_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %h got %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic regex_isa_pkg::instr_t enc_match(input logic [7:0] c);
    return {OP_MATCH, 6'd0, c};
  endfunction

  function automatic regex_isa_pkg::instr_t enc_split(input engine_types_pkg::pc_t a,
                                                      input engine_types_pkg::pc_t b);
    return {OP_SPLIT, a, b};
  endfunction

  function automatic regex_isa_pkg::instr_t enc_jmp(input engine_types_pkg::pc_t t);
    return {OP_JMP, 7'd0, t};
  endfunction

  task automatic load_programs();
    engine_types_pkg::pc_t p;
    for (int a = 0; a < 128; a++) prog[a] = {OP_MATCH, 6'd0, 1'b1, 7'(a)};  // no window letter
    prog[0] = enc_match("a");  // literal abcd, exits at pc 4
    prog[1] = enc_match("b");
    prog[2] = enc_match("c");
    prog[3] = enc_match("d");
    // one alternation block per character from pc 10, block 2 is (a|a)
    p = 7'd10;
    for (int k = 0; k < 4; k++) begin
      prog[p] = enc_split(p + 7'd1, p + 7'd3);
      prog[p + 7'd1] = enc_match("a");
      prog[p + 7'd2] = enc_jmp(p + 7'd5);
      prog[p + 7'd3] = enc_match((k == 2) ? "a" : "b");
      prog[p + 7'd4] = enc_jmp(p + 7'd5);
      p = p + 7'd5;
    end
    // accept before every character of xyxy, from pc 40
    p = 7'd40;
    for (int k = 0; k < 4; k++) begin
      prog[p] = enc_split(p + 7'd1, p + 7'd2);
      prog[p + 7'd1] = {OP_ACCEPT, 14'd0};
      prog[p + 7'd2] = enc_match((k % 2 == 0) ? "x" : "y");
      p = p + 7'd3;
    end
  endtask

  // walks all threads of a loop-free program over one window
  function automatic void reference_nfa(input engine_types_pkg::pc_t start,
                                        input logic [31:0] win, input int copies);
    engine_types_pkg::pc_t    stk_pc [64];
    engine_types_pkg::cc_id_t stk_ln [64];
    logic [5:0]               sp;
    engine_types_pkg::pc_t    pc;
    engine_types_pkg::cc_id_t ln;
    regex_isa_pkg::instr_t    ins;
    for (int p = 0; p < 128; p++) exp_counts[p] = 0;
    exp_accepts = 0;
    exp_total = 0;
    stk_pc[0] = start;
    stk_ln[0] = 2'd0;
    sp = 6'd1;
    while (sp != 6'd0) begin
      sp = sp - 6'd1;
      pc = stk_pc[sp];
      ln = stk_ln[sp];
      ins = prog[pc];
      case (ins[15:14])
        OP_MATCH: begin
          if (ins[7:0] == win[{ln, 3'b000} +: 8]) begin
            if (ln == 2'd3) begin  // leaves the window
              exp_counts[pc + 7'd1] += copies;
              exp_total += copies;
            end else begin
              stk_pc[sp] = pc + 7'd1;
              stk_ln[sp] = ln + 2'd1;
              sp = sp + 6'd1;
            end
          end
        end
        OP_SPLIT: begin
          stk_pc[sp] = ins[13:7];
          stk_ln[sp] = ln;
          sp = sp + 6'd1;
          stk_pc[sp] = ins[6:0];
          stk_ln[sp] = ln;
          sp = sp + 6'd1;
        end
        OP_JMP: begin
          stk_pc[sp] = ins[6:0];
          stk_ln[sp] = ln;
          sp = sp + 6'd1;
        end
        default: exp_accepts += copies;
      endcase
    end
  endfunction

  function automatic logic [31:0] random_window(input logic [7:0] c_lo, input logic [7:0] c_hi);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) w[i*8 +: 8] = ($random(stim_seed) & 1) ? c_hi : c_lo;
    return w;
  endfunction

  // memory answers each request after 1 to 4 cycles
  initial begin
    int delay;
    memory_ready = 1'b0;
    memory_data = '0;
    forever begin
      @(posedge clk);
      #1;
      if (memory_valid) begin
        delay = 1 + ($random(mem_seed) & 3);
        repeat (delay - 1) begin
          @(posedge clk);
          #1;
        end
        memory_data = prog[memory_addr];
        memory_ready = 1'b1;
        @(posedge clk);
        #1;
        memory_ready = 1'b0;
      end
    end
  end

  // inputs are steady from the falling edge to the next rising edge
  always @(negedge clk) begin
    if (!rst && output_pc_valid && output_pc_ready) begin
      check_value("output_pc_and_cc_id cc_id", 32'd0, 32'(output_pc_and_cc_id[1:0]));
      got_counts[output_pc_and_cc_id[8:2]]++;
      got_total++;
    end
    if (!rst && accepts) got_accepts++;
  end

  task automatic inject_thread(input engine_types_pkg::pc_t pc);
    input_pc_and_cc_id = {pc, 2'b00};
    input_pc_valid = 1'b1;
    @(negedge clk);
    while (!input_pc_ready) @(negedge clk);
    @(posedge clk);
    #1;
    input_pc_valid = 1'b0;
  endtask

  task automatic run_case(input engine_types_pkg::pc_t start, input logic [31:0] win,
                          input int copies, input int hold, input int gate_lane, input int gate);
    int stall;
    @(posedge clk);
    #1;
    reference_nfa(start, win, copies);
    run_total += exp_total;
    for (int p = 0; p < 128; p++) base_counts[p] = got_counts[p];
    base_accepts = got_accepts;
    base_total = got_total;
    stall = (hold > gate) ? hold : gate;
    cur_window = win;
    if (hold > 0) output_pc_ready = 1'b0;
    if (gate > 0) cur_window_enable[gate_lane] = 1'b0;
    for (int n = 0; n < copies; n++) inject_thread(start);
    repeat (stall) begin
      @(negedge clk);
      check_value("running", 32'd1, 32'(running));
      if (gate > 0) check_value("output_pc_valid", 32'd0, 32'(output_pc_valid));
    end
    @(posedge clk);
    #1;
    output_pc_ready = 1'b1;
    cur_window_enable = '1;
    @(negedge clk);
    while (running) @(negedge clk);
    for (int p = 0; p < 128; p++) begin
      check_value($sformatf("output_pc_and_cc_id pc %0d count", p), exp_counts[p],
                  got_counts[p] - base_counts[p]);
    end
    check_value("accepts", exp_accepts, got_accepts - base_accepts);
    check_value("thread_count", 32'd0, 32'(thread_count));
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the engine did not drain within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    rst = 1'b1;
    cur_window = '0;
    cur_window_enable = '1;
    input_pc_valid = 1'b0;
    input_pc_and_cc_id = '0;
    output_pc_ready = 1'b1;
    run_total = 0;
    load_programs();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_value("memory_valid", 32'd0, 32'(memory_valid));
    check_value("output_pc_valid", 32'd0, 32'(output_pc_valid));
    check_value("accepts", 32'd0, 32'(accepts));
    check_value("running", 32'd0, 32'(running));
    check_value("thread_count", 32'd0, 32'(thread_count));
    check_value("input_pc_ready", 32'd1, 32'(input_pc_ready));  // lane 0 fifo empty

    // char 0 is the rightmost letter
    run_case(7'd0, "dcba", 1, 0, 0, 0);
    check_value("output_pc_and_cc_id pc 4 count", 32'd1, got_counts[4] - base_counts[4]);
    run_case(7'd0, "dzba", 1, 0, 0, 0);
    check_value("output_pc_valid transfers", 32'd0, got_total - base_total);

    for (int n = 0; n < 6; n++) run_case(7'd10, random_window("a", "b"), 1, 0, 0, 0);
    for (int n = 0; n < 5; n++) run_case(7'd40, random_window("x", "y"), 1, 0, 0, 0);

    run_case(7'd10, "aaaa", 2, 20 + ($random(stim_seed) & 31), 0, 0);  // output stalled
    run_case(7'd0, "dcba", 2, 0, 2, 30);  // lane 2 gated

    if (got_total == run_total) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("[ERROR] output_pc_valid total expected %h got %h", run_total, got_total);
      $display("TEST RESULT: FAIL");
      $fatal(1, "output total mismatch");
    end
  end

endmodule

// File: logic/vectorial_engine.sv
`timescale 1ns/1ps
`include "regex_consts.svh"

module vectorial_engine (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [`LANES*`CHAR_WIDTH-1:0]   cur_window,  // char 0 in the low byte
  input  engine_types_pkg::lane_mask_t    cur_window_enable,
  input  logic                            input_pc_valid,
  input  engine_types_pkg::thread_t       input_pc_and_cc_id,
  output logic                            input_pc_ready,
  output logic                            output_pc_valid,
  output engine_types_pkg::thread_t       output_pc_and_cc_id,
  input  logic                            output_pc_ready,
  output logic                            memory_valid,
  output engine_types_pkg::pc_t           memory_addr,
  input  logic                            memory_ready,
  input  regex_isa_pkg::instr_t           memory_data,
  output logic                            accepts,
  output logic                            running,
  output engine_types_pkg::thread_count_t thread_count
);

  localparam int LAST = `LANES - 1;

  // arbiter side
  engine_types_pkg::lane_mask_t own_valid, own_ready;  // same-lane results
  engine_types_pkg::lane_mask_t adv_valid, adv_ready;  // threads entering from upstream
  engine_types_pkg::thread_t [`LANES-1:0] adv_data;
  engine_types_pkg::lane_mask_t arb_valid;
  engine_types_pkg::thread_t [`LANES-1:0] arb_data;

  // fifo side
  engine_types_pkg::lane_mask_t fifo_full, fifo_empty, fifo_wr;
  engine_types_pkg::thread_t [`LANES-1:0] fifo_dout;

  // cpu side
  engine_types_pkg::lane_mask_t cpu_in_valid, cpu_pop;
  engine_types_pkg::lane_mask_t cpu_out_valid, cpu_out_ready;
  engine_types_pkg::thread_t [`LANES-1:0] cpu_out_thread;
  engine_types_pkg::lane_mask_t cpu_spawn, cpu_retire, cpu_accept;
  engine_types_pkg::lane_mask_t fetch_req, fetch_done;
  logic [`LANES*`PC_WIDTH-1:0] fetch_addr;
  regex_isa_pkg::instr_t fetch_instr;

  logic in_xfer;
  logic out_xfer;

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    assign own_valid[i] = cpu_out_valid[i] &&
                          cpu_out_thread[i][`CC_ID_BITS-1:0] == engine_types_pkg::cc_id_t'(i);

    if (i == 0) begin : g_ext
      assign adv_valid[i] = input_pc_valid;
      assign adv_data[i]  = input_pc_and_cc_id;
    end else begin : g_prev
      assign adv_valid[i] = cpu_out_valid[i-1] && !own_valid[i-1];
      assign adv_data[i]  = cpu_out_thread[i-1];
    end

    // lane i result goes home or one lane down, the last lane leaves the engine
    if (i == LAST) begin : g_exit
      assign cpu_out_ready[i] = own_valid[i] ? own_ready[i] : output_pc_ready;
    end else begin : g_next
      assign cpu_out_ready[i] = own_valid[i] ? own_ready[i] : adv_ready[i+1];
    end

    assign fifo_wr[i]      = arb_valid[i] && !fifo_full[i];
    assign cpu_in_valid[i] = !fifo_empty[i] && cur_window_enable[i];

    thread_arbiter #(
      .ROUND_ROBIN(i != 0)  // lane 0 must never refuse the input port
    ) u_arb (
      .clk       (clk),
      .rst       (rst),
      .in_0_valid(own_valid[i]),
      .in_0_data (cpu_out_thread[i]),
      .in_0_ready(own_ready[i]),
      .in_1_valid(adv_valid[i]),
      .in_1_data (adv_data[i]),
      .in_1_ready(adv_ready[i]),
      .out_valid (arb_valid[i]),
      .out_data  (arb_data[i]),
      .out_ready (!fifo_full[i])
    );

    thread_fifo #(
      .DEPTH(`FIFO_DEPTH)
    ) u_fifo (
      .clk  (clk),
      .rst  (rst),
      .din  (arb_data[i]),
      .wr_en(fifo_wr[i]),
      .rd_en(cpu_pop[i]),
      .dout (fifo_dout[i]),
      .full (fifo_full[i]),
      .empty(fifo_empty[i])
    );

    regex_cpu #(
      .LANE_ID(i)
    ) u_cpu (
      .clk        (clk),
      .rst        (rst),
      .cur_char   (cur_window[i*`CHAR_WIDTH +: `CHAR_WIDTH]),
      .in_valid   (cpu_in_valid[i]),
      .in_thread  (fifo_dout[i]),
      .in_pop     (cpu_pop[i]),
      .fetch_req  (fetch_req[i]),
      .fetch_addr (fetch_addr[i*`PC_WIDTH +: `PC_WIDTH]),
      .fetch_done (fetch_done[i]),
      .fetch_instr(fetch_instr),
      .out_valid  (cpu_out_valid[i]),
      .out_thread (cpu_out_thread[i]),
      .out_ready  (cpu_out_ready[i]),
      .spawn      (cpu_spawn[i]),
      .retire     (cpu_retire[i]),
      .accept     (cpu_accept[i])
    );
  end

  fetch_arbiter u_fetch (
    .clk         (clk),
    .rst         (rst),
    .req         (fetch_req),
    .req_addr    (fetch_addr),
    .grant_done  (fetch_done),
    .instr       (fetch_instr),
    .memory_valid(memory_valid),
    .memory_addr (memory_addr),
    .memory_ready(memory_ready),
    .memory_data (memory_data)
  );

  assign input_pc_ready      = !fifo_full[0];
  assign output_pc_valid     = cpu_out_valid[LAST] && !own_valid[LAST];
  assign output_pc_and_cc_id = cpu_out_thread[LAST];
  assign accepts             = |cpu_accept;

  assign in_xfer  = input_pc_valid && input_pc_ready;
  assign out_xfer = output_pc_valid && output_pc_ready;

  thread_counter u_count (
    .clk    (clk),
    .rst    (rst),
    .spawn  ({in_xfer, cpu_spawn}),
    .retire ({out_xfer, cpu_retire}),
    .count  (thread_count),
    .running(running)
  );

  // new threads always start on the first character
  assert property (@(posedge clk) disable iff (rst)
    input_pc_valid |-> input_pc_and_cc_id[`CC_ID_BITS-1:0] == '0);

  // an accepted input thread really lands in the lane 0 fifo
  assert property (@(posedge clk) disable iff (rst) in_xfer |-> adv_ready[0] && fifo_wr[0]);

endmodule

// File: logic/thread_counter.sv
`timescale 1ns/1ps
`include "regex_consts.svh"

module thread_counter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [`LANES:0]                 spawn,   // lanes plus external input
  input  logic [`LANES:0]                 retire,  // lanes plus output port
  output engine_types_pkg::thread_count_t count,
  output logic                            running
);

  engine_types_pkg::thread_count_t n_spawn;
  engine_types_pkg::thread_count_t n_retire;

  assign n_spawn  = engine_types_pkg::thread_count_t'($countones(spawn));
  assign n_retire = engine_types_pkg::thread_count_t'($countones(retire));

  always_ff @(posedge clk) begin
    if (rst) count <= '0;
    else count <= count + n_spawn - n_retire;
  end

  assign running = count != '0;

  // a thread is never retired that was not counted in
  assert property (@(posedge clk) disable iff (rst) {1'b0, count} + n_spawn >= n_retire);

endmodule

// File: logic/regex_cpu.sv
`timescale 1ns/1ps
`include "regex_consts.svh"

module regex_cpu #(
  parameter int LANE_ID = 0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  regex_isa_pkg::char_t      cur_char,
  input  logic                      in_valid,
  input  engine_types_pkg::thread_t in_thread,
  output logic                      in_pop,
  output logic                      fetch_req,
  output engine_types_pkg::pc_t     fetch_addr,
  input  logic                      fetch_done,
  input  regex_isa_pkg::instr_t     fetch_instr,
  output logic                      out_valid,
  output engine_types_pkg::thread_t out_thread,
  input  logic                      out_ready,
  output logic                      spawn,
  output logic                      retire,
  output logic                      accept
);

  localparam engine_types_pkg::cc_id_t OWN_CC  = engine_types_pkg::cc_id_t'(LANE_ID);
  localparam engine_types_pkg::cc_id_t NEXT_CC = engine_types_pkg::cc_id_t'(LANE_ID + 1);

  engine_types_pkg::cpu_state_t state;
  engine_types_pkg::cpu_state_t state_next;
  engine_types_pkg::pc_t        pc_q;
  regex_isa_pkg::instr_t        instr_q;
  regex_isa_pkg::opcode_t       opcode;
  engine_types_pkg::pc_t        target_a;
  engine_types_pkg::pc_t        target_b;
  logic                         char_hit;
  logic                         drop;

  assign opcode   = regex_isa_pkg::opcode_t'(instr_q[`INSTR_WIDTH-1 -: `OPCODE_WIDTH]);
  assign target_a = instr_q[`PC_WIDTH +: `PC_WIDTH];  // split first target
  assign target_b = instr_q[`PC_WIDTH-1:0];           // jmp target or split second
  assign char_hit = instr_q[`CHAR_WIDTH-1:0] == cur_char;

  // thread ends here on accept or on a failed match
  assign drop = opcode == regex_isa_pkg::ACCEPT ||
                (opcode == regex_isa_pkg::MATCH && !char_hit);

  always_ff @(posedge clk) begin
    if (rst) state <= engine_types_pkg::IDLE;
    else state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (in_pop) pc_q <= in_thread[`CC_ID_BITS +: `PC_WIDTH];
    if (fetch_done) instr_q <= fetch_instr;
  end

  always_comb begin
    state_next = state;
    case (state)
      engine_types_pkg::IDLE: begin
        if (in_valid) state_next = engine_types_pkg::FETCH;
      end
      engine_types_pkg::FETCH: begin
        if (fetch_done) state_next = engine_types_pkg::EXEC;
      end
      engine_types_pkg::EXEC: begin
        state_next = drop ? engine_types_pkg::IDLE : engine_types_pkg::EMIT_A;
      end
      engine_types_pkg::EMIT_A: begin
        if (out_ready) begin
          state_next = (opcode == regex_isa_pkg::SPLIT) ? engine_types_pkg::EMIT_B
                                                        : engine_types_pkg::IDLE;
        end
      end
      engine_types_pkg::EMIT_B: begin
        if (out_ready) state_next = engine_types_pkg::IDLE;
      end
      default: state_next = engine_types_pkg::IDLE;
    endcase
  end

  // result thread, built from the held instruction
  always_comb begin
    out_thread = {target_b, OWN_CC};
    if (state == engine_types_pkg::EMIT_A && opcode == regex_isa_pkg::SPLIT) begin
      out_thread = {target_a, OWN_CC};
    end else if (opcode == regex_isa_pkg::MATCH) begin
      out_thread = {pc_q + 1'b1, NEXT_CC};  // moves on to the next character
    end
  end

  assign in_pop     = state == engine_types_pkg::IDLE && in_valid;
  assign fetch_req  = state == engine_types_pkg::FETCH;
  assign fetch_addr = pc_q;
  assign out_valid  = state == engine_types_pkg::EMIT_A || state == engine_types_pkg::EMIT_B;
  assign spawn      = state == engine_types_pkg::EMIT_B && out_ready;
  assign accept     = state == engine_types_pkg::EXEC && opcode == regex_isa_pkg::ACCEPT;
  assign retire     = state == engine_types_pkg::EXEC && drop;

  // routing must only hand this lane its own threads
  assert property (@(posedge clk) disable iff (rst)
    in_pop |-> in_thread[`CC_ID_BITS-1:0] == OWN_CC);

endmodule

// File: logic/fetch_arbiter.sv
`timescale 1ns/1ps
`include "regex_consts.svh"

module fetch_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  engine_types_pkg::lane_mask_t   req,
  input  logic [`LANES*`PC_WIDTH-1:0]    req_addr,
  output engine_types_pkg::lane_mask_t   grant_done,
  output regex_isa_pkg::instr_t          instr,
  output logic                           memory_valid,
  output engine_types_pkg::pc_t          memory_addr,
  input  logic                           memory_ready,
  input  regex_isa_pkg::instr_t          memory_data
);

  engine_types_pkg::lane_mask_t grant;  // one-hot while a fetch is out
  engine_types_pkg::cc_id_t ptr;        // first lane to look at
  engine_types_pkg::cc_id_t pick;
  engine_types_pkg::cc_id_t idx;
  logic found;

  // first requester at or after the pointer
  always_comb begin
    pick  = ptr;
    found = 1'b0;
    for (int k = 0; k < `LANES; k++) begin
      idx = ptr + engine_types_pkg::cc_id_t'(k);
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      ptr   <= '0;
    end else if (memory_valid) begin
      if (memory_ready) grant <= '0;
    end else if (found) begin
      grant <= engine_types_pkg::lane_mask_t'(1) << pick;
      ptr   <= pick + 1'b1;  // served lane goes last next time
    end
  end

  always_ff @(posedge clk) begin
    if (!memory_valid && found) memory_addr <= req_addr[pick*`PC_WIDTH +: `PC_WIDTH];
  end

  assign memory_valid = |grant;
  assign grant_done   = memory_ready ? grant : '0;
  assign instr        = memory_data;  // only the granted cpu samples it

  // the granted cpu keeps asking until its reply
  assert property (@(posedge clk) disable iff (rst)
    memory_valid |-> $onehot(grant) && |(grant & req));

endmodule

// File: logic/thread_arbiter.sv
`timescale 1ns/1ps

module thread_arbiter #(
  parameter bit ROUND_ROBIN = 1'b1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_0_valid,
  input  engine_types_pkg::thread_t in_0_data,
  output logic                      in_0_ready,
  input  logic                      in_1_valid,
  input  engine_types_pkg::thread_t in_1_data,
  output logic                      in_1_ready,
  output logic                      out_valid,
  output engine_types_pkg::thread_t out_data,
  input  logic                      out_ready
);

  logic last_1;  // in_1 won the last transfer
  logic pick_1;

  // fixed mode always lets in_1 through first, it carries the upstream threads
  assign pick_1 = in_1_valid && (!in_0_valid || !ROUND_ROBIN || !last_1);

  assign out_valid  = in_0_valid || in_1_valid;
  assign out_data   = pick_1 ? in_1_data : in_0_data;
  assign in_0_ready = out_ready && !pick_1;
  assign in_1_ready = out_ready && pick_1;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_1 <= 1'b0;
    end else if (out_valid && out_ready) begin
      last_1 <= pick_1;
    end
  end

  // a refused source keeps offering the same thread
  assert property (@(posedge clk) disable iff (rst)
    in_0_valid && !in_0_ready |=> in_0_valid && $stable(in_0_data));
  assert property (@(posedge clk) disable iff (rst)
    in_1_valid && !in_1_ready |=> in_1_valid && $stable(in_1_data));

endmodule

// File: logic/thread_fifo.sv
`timescale 1ns/1ps
`include "regex_consts.svh"

module thread_fifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  engine_types_pkg::thread_t din,
  input  logic                      wr_en,
  input  logic                      rd_en,
  output engine_types_pkg::thread_t dout,
  output logic                      full,
  output logic                      empty
);

  localparam int PTR_W = $clog2(DEPTH);

  engine_types_pkg::thread_t mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;

  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= bump(wr_ptr);
      if (rd_en) rd_ptr <= bump(rd_ptr);
      count <= count + {{PTR_W{1'b0}}, wr_en} - {{PTR_W{1'b0}}, rd_en};
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= din;
  end

  assign dout  = mem[rd_ptr];  // head shows without a read
  assign full  = count == (PTR_W + 1)'(DEPTH);
  assign empty = count == '0;

  // the arbiter and the cpu must both respect the flags
  assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);
  assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

// File: logic/engine_types_pkg.sv
`include "regex_consts.svh"

package engine_types_pkg;

  typedef logic [`PC_WIDTH-1:0] pc_t;
  typedef logic [`CC_ID_BITS-1:0] cc_id_t;

  // pc in the upper bits, cc_id in the lower ones
  typedef logic [`PC_WIDTH+`CC_ID_BITS-1:0] thread_t;

  typedef logic [`LANES-1:0] lane_mask_t;
  typedef logic [`THREAD_COUNT_WIDTH-1:0] thread_count_t;

  typedef enum logic [2:0] {
    IDLE,    // waiting for a thread
    FETCH,   // instruction request outstanding
    EXEC,
    EMIT_A,  // first (or only) result
    EMIT_B   // second split target
  } cpu_state_t;

endpackage

// File: logic/regex_isa_pkg.sv
`include "regex_consts.svh"

package regex_isa_pkg;

  // opcode lives in the top bits of every instruction
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    MATCH  = 2'b00,  // operand[7:0] is the character
    SPLIT  = 2'b01,  // operand[13:7] first target, operand[6:0] second
    JMP    = 2'b10,  // operand[6:0] is the target
    ACCEPT = 2'b11   // operand ignored
  } opcode_t;

  typedef logic [`INSTR_WIDTH-1:0] instr_t;
  typedef logic [`INSTR_WIDTH-`OPCODE_WIDTH-1:0] operand_t;
  typedef logic [`CHAR_WIDTH-1:0] char_t;

endpackage

// File: logic/regex_consts.svh
`ifndef REGEX_CONSTS_SVH
`define REGEX_CONSTS_SVH

// thread fields
`define PC_WIDTH 7
`define CC_ID_BITS 2
`define LANES (1 << `CC_ID_BITS)  // one lane per window character

// program and window
`define CHAR_WIDTH 8
`define INSTR_WIDTH 16
`define OPCODE_WIDTH 2  // top bits of an instruction

// storage and bookkeeping
`define FIFO_DEPTH 8
`define THREAD_COUNT_WIDTH 6

`endif
